// File: src/decode_pkg.sv
package decode_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths and scalar types
	//////////////////////////////////////////////////////////////////////

	localparam int BYTE_W  = 8;                 // data and opcode width
	localparam int CYCLE_W = 3;                 // instruction cycle counter
	localparam int OP_W    = 4;                 // operation class code
	localparam int MODE_W  = 2;                 // addressing mode code

	typedef logic [BYTE_W-1:0]  byte_t;         // one bus byte
	typedef logic [CYCLE_W-1:0] cycle_t;        // cycle within an instruction

	// brk is outside the kept set, so a fresh sequencer decodes as unknown
	localparam byte_t RESET_OPCODE = 8'h00;

	//////////////////////////////////////////////////////////////////////
	// opcodes, operations and modes
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [BYTE_W-1:0] {
		ADC_IMM = 8'h69,                        // add with carry
		ADC_ZPG = 8'h65,
		ADC_ABS = 8'h6d,
		SBC_IMM = 8'he9,                        // subtract with borrow
		SBC_ZPG = 8'he5,
		SBC_ABS = 8'hed,
		CMP_IMM = 8'hc9,                        // compares against a, x, y
		CPX_IMM = 8'he0,
		CPY_IMM = 8'hc0,
		SEC     = 8'h38,                        // carry set / clear
		CLC     = 8'h18,
		INX     = 8'he8,                        // index steps
		DEX     = 8'hca,
		INY     = 8'hc8,
		DEY     = 8'h88,
		TAX     = 8'haa,                        // register transfers
		TXA     = 8'h8a,
		TAY     = 8'ha8,
		TYA     = 8'h98
	} opcode_e;

	typedef enum logic [OP_W-1:0] {
		OP_NONE,                                // unknown byte, plain fetch
		OP_ADC,
		OP_SBC,
		OP_CMP,
		OP_CPX,
		OP_CPY,
		OP_FLAGC,                               // sec and clc share one path
		OP_INX,
		OP_DEX,
		OP_INY,
		OP_DEY,
		OP_TAX,
		OP_TXA,
		OP_TAY,
		OP_TYA
	} op_class_e;

	typedef enum logic [MODE_W-1:0] {
		AM_IMPL,                                // one byte, no operand
		AM_IMM,                                 // operand follows opcode
		AM_ZPG,                                 // one address byte, page 0
		AM_ABS                                  // two address bytes
	} addr_mode_e;

	//////////////////////////////////////////////////////////////////////
	// control line bundles
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic next_cycle;                       // step the cycle counter
		logic restart;                          // back to cycle 0, load ir
	} seq_ctl_t;

	typedef struct packed {
		logic dl_db;                            // data latch onto db
		logic ac_sb;
		logic ac_db;
		logic add_sb;                           // alu result onto sb
		logic sb_ac;
		logic sb_db;                            // sb / db bridge
		logic sb_x;
		logic sb_y;
		logic x_sb;
		logic y_sb;
		logic dl_adh;
		logic dl_adl;
		logic add_adl;                          // alu result onto adl
		logic z_adh;                            // zeros onto adh
	} bus_ctl_t;

	typedef struct packed {
		logic pcl_adl;
		logic pch_adh;
		logic adl_abl;                          // load address bus low
		logic adh_abh;                          // load address bus high
	} addr_ctl_t;

	typedef struct packed {
		logic pc_inc;
		logic pcl_pcl;                          // pc low recirculate
		logic pch_pch;                          // pc high recirculate
	} pc_ctl_t;

	typedef struct packed {
		logic sb_add;                           // a input from sb
		logic db_add;                           // b input from db
		logic ndb_add;                          // b input from inverted db
		logic z_add;                            // a input forced to zero
		logic none_add;                         // b input forced to all ones
		logic c_one;                            // carry in forced high
		logic sums;                             // alu adds
	} alu_ctl_t;

	typedef struct packed {
		logic avr_v;
		logic acr_c;
		logic dbz_z;
		logic db7_n;
		logic ir5_c;                            // carry from opcode bit 5
	} flag_ctl_t;

	typedef struct packed {
		seq_ctl_t  seq;
		bus_ctl_t  bus;
		addr_ctl_t addr;
		pc_ctl_t   pc;
		alu_ctl_t  alu;
		flag_ctl_t flag;
	} ctrl_word_t;

endpackage

// File: src/opcode_classifier.sv
`timescale 1ns/1ps

module opcode_classifier (
	input  decode_pkg::byte_t      ir,
	output decode_pkg::op_class_e  op,
	output decode_pkg::addr_mode_e mode
);

	always_comb begin
		op   = decode_pkg::OP_NONE;             // anything off the table
		mode = decode_pkg::AM_IMPL;
		case (ir)
			decode_pkg::ADC_IMM: begin
				op   = decode_pkg::OP_ADC;
				mode = decode_pkg::AM_IMM;
			end
			decode_pkg::ADC_ZPG: begin
				op   = decode_pkg::OP_ADC;
				mode = decode_pkg::AM_ZPG;
			end
			decode_pkg::ADC_ABS: begin
				op   = decode_pkg::OP_ADC;
				mode = decode_pkg::AM_ABS;
			end
			decode_pkg::SBC_IMM: begin
				op   = decode_pkg::OP_SBC;
				mode = decode_pkg::AM_IMM;
			end
			decode_pkg::SBC_ZPG: begin
				op   = decode_pkg::OP_SBC;
				mode = decode_pkg::AM_ZPG;
			end
			decode_pkg::SBC_ABS: begin
				op   = decode_pkg::OP_SBC;
				mode = decode_pkg::AM_ABS;
			end
			decode_pkg::CMP_IMM: begin
				op   = decode_pkg::OP_CMP;
				mode = decode_pkg::AM_IMM;
			end
			decode_pkg::CPX_IMM: begin
				op   = decode_pkg::OP_CPX;
				mode = decode_pkg::AM_IMM;
			end
			decode_pkg::CPY_IMM: begin
				op   = decode_pkg::OP_CPY;
				mode = decode_pkg::AM_IMM;
			end
			// single byte group, mode stays implied
			decode_pkg::SEC,
			decode_pkg::CLC: op = decode_pkg::OP_FLAGC;    // bit 5 picks set or clear
			decode_pkg::INX: op = decode_pkg::OP_INX;
			decode_pkg::DEX: op = decode_pkg::OP_DEX;
			decode_pkg::INY: op = decode_pkg::OP_INY;
			decode_pkg::DEY: op = decode_pkg::OP_DEY;
			decode_pkg::TAX: op = decode_pkg::OP_TAX;
			decode_pkg::TXA: op = decode_pkg::OP_TXA;
			decode_pkg::TAY: op = decode_pkg::OP_TAY;
			decode_pkg::TYA: op = decode_pkg::OP_TYA;
			default: begin
				op   = decode_pkg::OP_NONE;     // unsupported byte
				mode = decode_pkg::AM_IMPL;
			end
		endcase
	end

endmodule

// File: src/cycle_sequencer.sv
`timescale 1ns/1ps

module cycle_sequencer (
	input  logic                  clk_ph2,
	input  logic                  rst,
	input  decode_pkg::seq_ctl_t  seq,
	input  decode_pkg::byte_t     ir,
	output decode_pkg::cycle_t    cycle,
	output decode_pkg::byte_t     opcode
);

	decode_pkg::cycle_t cycle_inc;          // counter plus one

	assign cycle_inc = cycle + decode_pkg::cycle_t'(1);

	//////////////////////////////////////////////////////////////////////
	// cycle counter
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_ph2) begin
		if (!rst) begin
			cycle <= '0;                    // start on the opcode cycle
		end else if (seq.restart) begin
			cycle <= '0;                    // last word of the instruction
		end else if (seq.next_cycle) begin
			cycle <= cycle_inc;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// opcode latch
	//////////////////////////////////////////////////////////////////////

	// the byte on ir during the restart word becomes the next instruction
	always_ff @(posedge clk_ph2) begin
		if (!rst) begin
			opcode <= decode_pkg::RESET_OPCODE; // decodes as a bare fetch
		end else if (seq.restart) begin
			opcode <= ir;                   // next opcode sampled here
		end
	end

endmodule

// File: src/step_decoder.sv
`timescale 1ns/1ps

module step_decoder (
	input  decode_pkg::op_class_e  op,
	input  decode_pkg::addr_mode_e mode,
	input  decode_pkg::cycle_t     cycle,
	output decode_pkg::ctrl_word_t word
);

	localparam decode_pkg::cycle_t CY_OPCODE = 'd0;    // store and fetch
	localparam decode_pkg::cycle_t CY_OPER1  = 'd1;    // first operand byte
	localparam decode_pkg::cycle_t CY_OPER2  = 'd2;
	localparam decode_pkg::cycle_t CY_OPER3  = 'd3;    // absolute only

	//////////////////////////////////////////////////////////////////////
	// shared word pieces
	//////////////////////////////////////////////////////////////////////

	// pc onto the address bus, pc held in its own latches
	function automatic decode_pkg::ctrl_word_t with_fetch(input decode_pkg::ctrl_word_t w,
			input logic inc);
		decode_pkg::ctrl_word_t f;
		f = w;
		f.addr.pcl_adl = 1'b1;
		f.addr.pch_adh = 1'b1;
		f.addr.adl_abl = 1'b1;
		f.addr.adh_abh = 1'b1;
		f.pc.pcl_pcl   = 1'b1;
		f.pc.pch_pch   = 1'b1;
		f.pc.pc_inc    = inc;                   // low for one byte opcodes
		return f;
	endfunction

	// register on sb, data latch on db, alu adds
	function automatic decode_pkg::ctrl_word_t with_arith(input decode_pkg::ctrl_word_t w,
			input decode_pkg::op_class_e o);
		decode_pkg::ctrl_word_t f;
		logic                   is_cmp;
		f        = w;
		is_cmp   = (o == decode_pkg::OP_CMP) || (o == decode_pkg::OP_CPX) ||
			(o == decode_pkg::OP_CPY);
		f.bus.dl_db   = 1'b1;                   // operand byte
		f.bus.x_sb    = (o == decode_pkg::OP_CPX);
		f.bus.y_sb    = (o == decode_pkg::OP_CPY);
		f.bus.ac_sb   = (o != decode_pkg::OP_CPX) && (o != decode_pkg::OP_CPY);
		f.alu.sb_add  = 1'b1;
		f.alu.db_add  = (o == decode_pkg::OP_ADC);
		f.alu.ndb_add = (o != decode_pkg::OP_ADC); // subtract adds the inverse
		f.alu.c_one   = is_cmp;                 // compare ignores the carry flag
		f.alu.sums    = 1'b1;
		return f;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// cycle table
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		word = '0;
		case (cycle)
			CY_OPCODE: begin
				word = with_fetch(word, 1'b1);
				word.seq.next_cycle = 1'b1;
				case (op)
					decode_pkg::OP_ADC, decode_pkg::OP_SBC: begin
						word.bus.add_sb  = 1'b1;    // sum into a through sb
						word.bus.sb_ac   = 1'b1;
						word.bus.sb_db   = 1'b1;    // flags read it on db
						word.flag.avr_v  = 1'b1;
						word.flag.acr_c  = 1'b1;
						word.flag.dbz_z  = 1'b1;
						word.flag.db7_n  = 1'b1;
					end
					decode_pkg::OP_CMP, decode_pkg::OP_CPX, decode_pkg::OP_CPY: begin
						word.flag.acr_c  = 1'b1;    // result itself is dropped
						word.flag.dbz_z  = 1'b1;
						word.flag.db7_n  = 1'b1;
					end
					decode_pkg::OP_INX, decode_pkg::OP_DEX,
					decode_pkg::OP_INY, decode_pkg::OP_DEY: begin
						word.bus.add_sb  = 1'b1;
						word.bus.sb_x    = (op == decode_pkg::OP_INX) || (op == decode_pkg::OP_DEX);
						word.bus.sb_y    = (op == decode_pkg::OP_INY) || (op == decode_pkg::OP_DEY);
						word.bus.sb_db   = 1'b1;
						word.flag.dbz_z  = 1'b1;
						word.flag.db7_n  = 1'b1;
					end
					default: ;                      // flags, transfers, unknown just fetch
				endcase
			end
			CY_OPER1: begin
				case (mode)
					decode_pkg::AM_IMM: begin
						word = with_fetch(word, 1'b1);  // operand byte read here
						word.seq.restart = 1'b1;
						word = with_arith(word, op);
					end
					decode_pkg::AM_ZPG: begin
						word.bus.dl_adl  = 1'b1;    // address byte to abl
						word.bus.z_adh   = 1'b1;    // page zero
						word.addr.adl_abl = 1'b1;
						word.addr.adh_abh = 1'b1;
						word.seq.next_cycle = 1'b1;
					end
					decode_pkg::AM_ABS: begin
						word = with_fetch(word, 1'b1);  // high address byte next
						word.seq.next_cycle = 1'b1;
						word.bus.dl_db   = 1'b1;    // park low byte in the alu
						word.alu.db_add  = 1'b1;
						word.alu.z_add   = 1'b1;
						word.alu.sums    = 1'b1;
					end
					default: begin
						word.seq.restart = 1'b1;
						word = with_fetch(word, op == decode_pkg::OP_NONE);
						case (op)
							decode_pkg::OP_FLAGC: word.flag.ir5_c = 1'b1;
							decode_pkg::OP_INX, decode_pkg::OP_DEX,
							decode_pkg::OP_INY, decode_pkg::OP_DEY: begin
								word.bus.x_sb   = (op == decode_pkg::OP_INX) ||
									(op == decode_pkg::OP_DEX);
								word.bus.y_sb   = (op == decode_pkg::OP_INY) ||
									(op == decode_pkg::OP_DEY);
								word.bus.sb_db  = 1'b1; // index reaches the b input
								word.alu.db_add = 1'b1;
								word.alu.sums   = 1'b1;
								// plus one as zero with carry, minus one as all ones
								word.alu.z_add    = (op == decode_pkg::OP_INX) ||
									(op == decode_pkg::OP_INY);
								word.alu.c_one    = word.alu.z_add;
								word.alu.none_add = !word.alu.z_add;
							end
							decode_pkg::OP_TAX, decode_pkg::OP_TAY: begin
								word.bus.ac_sb  = 1'b1;
								word.bus.ac_db  = 1'b1; // flags see a on db
								word.bus.sb_x   = (op == decode_pkg::OP_TAX);
								word.bus.sb_y   = (op == decode_pkg::OP_TAY);
								word.flag.dbz_z = 1'b1;
								word.flag.db7_n = 1'b1;
							end
							decode_pkg::OP_TXA, decode_pkg::OP_TYA: begin
								word.bus.x_sb   = (op == decode_pkg::OP_TXA);
								word.bus.y_sb   = (op == decode_pkg::OP_TYA);
								word.bus.sb_db  = 1'b1;
								word.bus.sb_ac  = 1'b1;
								word.flag.dbz_z = 1'b1;
								word.flag.db7_n = 1'b1;
							end
							default: ;              // unknown byte ends its fetch
						endcase
					end
				endcase
			end
			CY_OPER2: begin
				if (mode == decode_pkg::AM_ABS) begin
					word.bus.add_adl  = 1'b1;       // low byte back out of the alu
					word.bus.dl_adh   = 1'b1;       // high byte from the latch
					word.addr.adl_abl = 1'b1;
					word.addr.adh_abh = 1'b1;
					word.seq.next_cycle = 1'b1;
				end else begin
					word = with_fetch(word, 1'b1);  // zero page data is in dl
					word.seq.restart = 1'b1;
					if (mode == decode_pkg::AM_ZPG) begin
						word = with_arith(word, op);
					end
				end
			end
			CY_OPER3: begin
				word = with_fetch(word, 1'b1);
				word.seq.restart = 1'b1;
				if (mode == decode_pkg::AM_ABS) begin
					word = with_arith(word, op);    // absolute data is in dl
				end
			end
			default: begin
				word = with_fetch(word, 1'b1);      // stray count recovers here
				word.seq.restart = 1'b1;
			end
		endcase
	end

endmodule

// File: src/instruction_decoder.sv
`timescale 1ns/1ps

module instruction_decoder (
	input  logic                   clk_ph2,
	input  logic                   rst,
	input  decode_pkg::byte_t      ir,
	output decode_pkg::ctrl_word_t ctrl
);

	decode_pkg::byte_t      opcode;         // latched instruction
	decode_pkg::cycle_t     cycle;          // step within it
	decode_pkg::op_class_e  op;
	decode_pkg::addr_mode_e mode;
	decode_pkg::ctrl_word_t word;           // combinational next word

	//////////////////////////////////////////////////////////////////////
	// decode path
	//////////////////////////////////////////////////////////////////////

	cycle_sequencer u_seq (
		.clk_ph2 (clk_ph2),
		.rst     (rst),
		.seq     (word.seq),                // steps on the same edge as ctrl
		.ir      (ir),
		.cycle   (cycle),
		.opcode  (opcode)
	);

	opcode_classifier u_class (
		.ir   (opcode),
		.op   (op),
		.mode (mode)
	);

	step_decoder u_step (
		.op    (op),
		.mode  (mode),
		.cycle (cycle),
		.word  (word)
	);

	// one word per clock, no stall
	always_ff @(posedge clk_ph2) begin
		if (!rst) begin
			ctrl <= '0;                     // all lines idle
		end else begin
			ctrl <= word;
		end
	end

endmodule

// File: tb/decoder_assert.sv
`timescale 1ns/1ps

module decoder_assert (
	input logic                   clk_ph2,
	input logic                   rst,
	input decode_pkg::ctrl_word_t ctrl
);

	int fail_fetch = 0;                         // per assertion failure counts
	int fail_sb    = 0;
	int fail_seq   = 0;
	int fail_abl   = 0;
	int fails;                                  // summed for the testbench

	assign fails = fail_fetch + fail_sb + fail_seq + fail_abl;

	//////////////////////////////////////////////////////////////////////
	// first instruction after reset
	//////////////////////////////////////////////////////////////////////

	// word one of the reset fetch steps the counter
	fetch_first: assert property (@(posedge clk_ph2)
		(rst && $past(rst) && !$past(rst, 2)) |-> ctrl.seq.next_cycle)
		else begin
			fail_fetch++;
			$error("reset fetch first word lacks next_cycle");
		end

	// word two ends it
	fetch_second: assert property (@(posedge clk_ph2)
		(rst && $past(rst) && $past(rst, 2) && !$past(rst, 3)) |-> ctrl.seq.restart)
		else begin
			fail_fetch++;
			$error("reset fetch second word lacks restart");
		end

	//////////////////////////////////////////////////////////////////////
	// bus rules on every word
	//////////////////////////////////////////////////////////////////////

	sb_single: assert property (@(posedge clk_ph2)
		$onehot0({ctrl.bus.ac_sb, ctrl.bus.add_sb, ctrl.bus.x_sb, ctrl.bus.y_sb}))
		else begin
			fail_sb++;
			$error("more than one source drives sb");
		end

	seq_exclusive: assert property (@(posedge clk_ph2)
		!(ctrl.seq.next_cycle && ctrl.seq.restart))
		else begin
			fail_seq++;
			$error("next_cycle and restart set together");
		end

	abl_source: assert property (@(posedge clk_ph2)
		ctrl.addr.adl_abl |-> $onehot({ctrl.addr.pcl_adl, ctrl.bus.dl_adl, ctrl.bus.add_adl}))
		else begin
			fail_abl++;
			$error("adl_abl set without exactly one adl source");
		end

endmodule

// File: tb/tb_decoder.sv
`timescale 1ns/1ps

module tb_decoder;

	logic                   clk_ph2;
	logic                   rst;
	logic [7:0]             ir;
	decode_pkg::ctrl_word_t ctrl;

	logic [7:0] kept_ops [0:18];                // every opcode the decoder keeps
	logic [7:0] odd_ops [0:3];                  // bytes outside the table
	logic [7:0] stream [$];                     // opcodes in issue order
	integer     seed;
	logic [4:0] pick;
	logic       rst_q = 1'b0;                   // rst as the dut sampled it
	logic       done = 1'b0;
	int         errors = 0;
	int         restarts = 0;                   // restart words seen so far
	int         words = 0;                      // words of the current instruction
	int         incs = 0;                       // its pc_inc words
	int         cycles = 0;
	int         limit;
	int         fed;                            // stream entries put on ir
	int         total;

	instruction_decoder uut (
		.clk_ph2 (clk_ph2),
		.rst     (rst),
		.ir      (ir),
		.ctrl    (ctrl)
	);

	bind instruction_decoder decoder_assert chk (
		.clk_ph2 (clk_ph2),
		.rst     (rst),
		.ctrl    (ctrl)
	);

	//////////////////////////////////////////////////////////////////////
	// opcode table
	//////////////////////////////////////////////////////////////////////

	// 0 unknown, 1 implied, 2 immediate, 3 zero page, 4 absolute
	function automatic int mode_of(input logic [7:0] b);
		case (b)
			8'h69, 8'he9, 8'hc9, 8'he0, 8'hc0: return 2;
			8'h65, 8'he5: return 3;
			8'h6d, 8'hed: return 4;
			8'h38, 8'h18, 8'he8, 8'hca, 8'hc8: return 1;
			8'h88, 8'haa, 8'h8a, 8'ha8, 8'h98: return 1;
			default: return 0;
		endcase
	endfunction

	function automatic int word_len(input int m);
		case (m)
			3: return 3;
			4: return 4;
			default: return 2;                  // implied, immediate, unknown
		endcase
	endfunction

	function automatic int byte_count(input int m);
		case (m)
			1: return 1;
			2, 3: return 2;
			4: return 3;
			default: return -1;                 // unknown bytes not counted
		endcase
	endfunction

	// reset fetch first, then the stream in order
	function automatic logic [7:0] current_opcode();
		if (restarts == 0)
			return 8'h00;
		return stream[restarts-1];
	endfunction

	//////////////////////////////////////////////////////////////////////
	// per word and per instruction checks
	//////////////////////////////////////////////////////////////////////

	task automatic check_word(input logic [7:0] b, input int n);
		logic is_sub;
		logic is_cmp;
		is_sub = (b == 8'he9) || (b == 8'he5) || (b == 8'hed);
		is_cmp = (b == 8'hc9) || (b == 8'he0) || (b == 8'hc0);
		if ((is_sub || is_cmp) && n == word_len(mode_of(b))) begin  // operand word
			assert ({ctrl.alu.sums, ctrl.alu.ndb_add, ctrl.alu.db_add} == 3'b110) else begin
				errors++;
				$display("Fail sub_operand %h: expected %b actual %b", b, 3'b110,
					{ctrl.alu.sums, ctrl.alu.ndb_add, ctrl.alu.db_add});
			end
			if (is_cmp) begin
				assert (ctrl.alu.c_one) else begin
					errors++;
					$display("Fail cmp_carry %h: expected 1 actual %b", b, ctrl.alu.c_one);
				end
			end
		end
		if (n == 2) begin
			case (b)
				8'h38, 8'h18: assert (ctrl.flag.ir5_c) else begin
					errors++;
					$display("Fail flag_carry %h: expected 1 actual %b", b, ctrl.flag.ir5_c);
				end
				8'he8, 8'hc8, 8'hca, 8'h88: assert ({ctrl.alu.z_add, ctrl.alu.none_add} ==
						((b == 8'he8 || b == 8'hc8) ? 2'b10 : 2'b01)) else begin
					errors++;
					$display("Fail index_step %h: expected %b actual %b", b,
						(b == 8'he8 || b == 8'hc8) ? 2'b10 : 2'b01,
						{ctrl.alu.z_add, ctrl.alu.none_add});
				end
				8'haa, 8'h8a, 8'ha8, 8'h98: assert ({ctrl.flag.dbz_z, ctrl.flag.db7_n} == 2'b11)
					else begin
					errors++;
					$display("Fail transfer_flags %h: expected 11 actual %b", b,
						{ctrl.flag.dbz_z, ctrl.flag.db7_n});
				end
				default: ;                          // no second word rule
			endcase
		end
	endtask

	task automatic verify_instr(input logic [7:0] b);
		assert (words == word_len(mode_of(b))) else begin
			errors++;
			$display("Fail length %h: expected %0d actual %0d", b, word_len(mode_of(b)), words);
		end
		if (byte_count(mode_of(b)) >= 0) begin
			assert (incs == byte_count(mode_of(b))) else begin
				errors++;
				$display("Fail pc_inc %h: expected %0d actual %0d", b,
					byte_count(mode_of(b)), incs);
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// clock, monitor, stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		clk_ph2 = 1'b0;
		forever #4 clk_ph2 = ~clk_ph2;          // 8 ns period
	end

	always @(posedge clk_ph2) rst_q <= rst;

	// sample between edges where ctrl is stable
	always @(negedge clk_ph2) begin
		if (!rst_q) begin
			assert (ctrl == '0) else begin
				errors++;
				$display("Fail reset: expected %h actual %h", 35'h0, ctrl);
			end
		end else if (!done) begin
			words = words + 1;
			if (ctrl.pc.pc_inc)
				incs = incs + 1;
			check_word(current_opcode(), words);
			if (ctrl.seq.restart) begin         // instruction boundary
				verify_instr(current_opcode());
				restarts = restarts + 1;
				words = 0;
				incs = 0;
				if (restarts == stream.size() + 1)
					done = 1'b1;
			end
		end
	end

	initial begin
		kept_ops = '{8'h69, 8'h65, 8'h6d, 8'he9, 8'he5, 8'hed, 8'hc9, 8'he0, 8'hc0, 8'h38,
			8'h18, 8'he8, 8'hca, 8'hc8, 8'h88, 8'haa, 8'h8a, 8'ha8, 8'h98};
		odd_ops = '{8'h00, 8'hea, 8'h4c, 8'hff};
		seed = 32'h6505;
		for (int i = 0; i < 19; i++)
			stream.push_back(kept_ops[i]);
		for (int i = 0; i < 40; i++) begin
			pick = 5'($unsigned($random(seed)) % 23);   // 4 in 23 are unknown
			if (pick < 5'd19)
				stream.push_back(kept_ops[pick]);
			else
				stream.push_back(odd_ops[2'(pick - 5'd19)]);
		end
		limit = 4 * (stream.size() + 1) + 50;   // reset fetch counts as one
		rst = 1'b0;
		ir = stream[0];
		fed = 1;
		repeat (3) begin
			@(posedge clk_ph2);
			cycles++;
		end
		rst <= 1'b1;
		while (!done && cycles < limit) begin
			@(posedge clk_ph2);
			cycles++;
			if (restarts == fed) begin          // show the next opcode once the last is latched
				ir <= (fed < stream.size()) ? stream[fed] : 8'hea;
				fed++;
			end
		end
		if (!done) begin
			errors++;
			$display("timeout: %0d of %0d instructions finished in %0d cycles", restarts,
				stream.size() + 1, cycles);
		end
		total = errors + uut.chk.fails;
		$display("summary: %0d instructions, %0d check errors, %0d assertion errors",
			restarts, errors, uut.chk.fails);
		if (total == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: tb.f
src/decode_pkg.sv
src/opcode_classifier.sv
src/cycle_sequencer.sv
src/step_decoder.sv
src/instruction_decoder.sv
tb/decoder_assert.sv
tb/tb_decoder.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f tb.f --top-module tb_decoder -o sim_decoder

out=$(./obj_dir/sim_decoder +verilator+error+limit+1000 || true)
echo "$out"

echo "$out" | grep -qx "ALL CHECKS PASSED"
